// File: design/read_engine_pkg.sv
// Read engine cluster package
// Shared address type, engine states and default sizes for the
// serial read engines and their request arbiter

package read_engine_pkg;

    // ----------------------------------------
    // Address and offset type
    // ----------------------------------------
    parameter int ADDR_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // ----------------------------------------
    // Engine FSM states
    // ----------------------------------------
    // SETUP loads the offset counter, BUSY pushes offsets,
    // PAUSE waits on a nearly full request FIFO
    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        BUSY,
        PAUSE,
        DONE
    } engine_state_t;

    // ----------------------------------------
    // Default cluster sizes
    // ----------------------------------------
    // Peer engines sharing one request port
    parameter int DEFAULT_NUM_ENGINES = 2;

    // Request FIFO slots per engine
    parameter int DEFAULT_FIFO_DEPTH = 16;

    // Request slots held by the memory side
    parameter int DEFAULT_NUM_CREDITS = 4;

endpackage : read_engine_pkg

// File: design/request_fifo.sv
// Request offset FIFO
// First-word-fall-through circular buffer of read offsets, with an
// almost-full flag raised when two or fewer slots remain

module request_fifo #(
    parameter int FIFO_DEPTH = read_engine_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                   ap_clk,
    input  logic                   engine_areset,
    input  logic                   push,
    input  read_engine_pkg::addr_t push_offset,
    input  logic                   pop,
    output read_engine_pkg::addr_t head_offset,
    output logic                   not_empty,
    output logic                   almost_full
);
    import read_engine_pkg::*;

    localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(FIFO_DEPTH - 1);

    addr_t                mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 full;
    logic                 wr_en;
    logic                 rd_en;

    // Almost-full needs a few slots to mean anything
    if (FIFO_DEPTH < 3) begin : g_depth_check
        $error("request_fifo: FIFO_DEPTH must be at least 3");
    end

    assign full        = (count == CNT_WIDTH'(FIFO_DEPTH));
    assign not_empty   = (count != '0);
    assign almost_full = (count >= CNT_WIDTH'(FIFO_DEPTH - 2));
    assign wr_en       = push && !full;
    assign rd_en       = pop && not_empty;

    // Head of queue is visible without a read cycle
    assign head_offset = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_offset;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (engine_areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : request_fifo

// File: design/serial_read_engine.sv
// Serial read engine
// Walks an offset range from start_read towards end_read by stride and
// queues one request offset per step in its own request FIFO. Pauses
// while the FIFO is nearly full and resumes without skipping offsets.

module serial_read_engine #(
    parameter int ENGINE_ID  = 0,
    parameter int FIFO_DEPTH = read_engine_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                   ap_clk,
    input  logic                   engine_areset,
    input  logic                   cfg_valid,
    input  logic                   start,
    input  read_engine_pkg::addr_t start_read,
    input  read_engine_pkg::addr_t end_read,
    input  read_engine_pkg::addr_t stride,
    output logic                   ready,
    output logic                   done,
    input  logic                   pop,
    output logic                   not_empty,
    output read_engine_pkg::addr_t head_offset
);
    import read_engine_pkg::*;

    engine_state_t state;
    engine_state_t next_state;

    addr_t offset;
    addr_t end_q;
    addr_t stride_q;

    logic ready_q;
    logic done_q;
    logic range_left;
    logic push;
    logic fifo_almost_full;

    if (ENGINE_ID < 0) begin : g_id_check
        $error("serial_read_engine: ENGINE_ID must not be negative");
    end

    // ----------------------------------------
    // Offset stepping
    // ----------------------------------------
    assign range_left = (offset < end_q);

    // Never pushes into a nearly full FIFO, so it can never overflow
    assign push = (state == BUSY) && range_left && !fifo_almost_full;

    always_ff @(posedge ap_clk) begin
        if (state == SETUP) begin
            offset   <= start_read;
            end_q    <= end_read;
            stride_q <= stride;
        end else if (push) begin
            offset <= offset + stride_q;
        end
    end

    // ----------------------------------------
    // Engine FSM
    // ----------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (cfg_valid && start) begin
                    next_state = SETUP;
                end
            end
            SETUP: begin
                next_state = BUSY;
            end
            BUSY: begin
                // Finished only once every queued offset has left
                if (!range_left && !not_empty) begin
                    next_state = DONE;
                end else if (fifo_almost_full) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (!fifo_almost_full) begin
                    next_state = BUSY;
                end
            end
            DONE: begin
                // Hold done until the host drops start
                if (!start) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (engine_areset) begin
            state   <= IDLE;
            ready_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state   <= next_state;
            ready_q <= (next_state == IDLE);
            done_q  <= (next_state == DONE);
        end
    end

    assign ready = ready_q;
    assign done  = done_q;

    // ----------------------------------------
    // Request queue
    // ----------------------------------------
    request_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_request_fifo (
        .ap_clk       (ap_clk),
        .engine_areset(engine_areset),
        .push         (push),
        .push_offset  (offset),
        .pop          (pop),
        .head_offset  (head_offset),
        .not_empty    (not_empty),
        .almost_full  (fifo_almost_full)
    );

endmodule : serial_read_engine

// File: design/request_arbiter.sv
// Request arbiter
// Round-robin grant among the engine FIFOs onto one memory request
// port, gated by a credit counter towards the memory side

module request_arbiter #(
    parameter int NUM_ENGINES = read_engine_pkg::DEFAULT_NUM_ENGINES,
    parameter int NUM_CREDITS = read_engine_pkg::DEFAULT_NUM_CREDITS,
    localparam int ID_WIDTH   = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1
) (
    input  logic                   ap_clk,
    input  logic                   engine_areset,
    input  logic [NUM_ENGINES-1:0] not_empty,
    input  read_engine_pkg::addr_t head_offset [NUM_ENGINES],
    input  read_engine_pkg::addr_t array_pointer [NUM_ENGINES],
    output logic [NUM_ENGINES-1:0] pop,
    input  logic                   credit_return,
    output logic                   req_valid,
    output logic [ID_WIDTH-1:0]    req_engine_id,
    output read_engine_pkg::addr_t req_base_address,
    output read_engine_pkg::addr_t req_address_offset
);
    import read_engine_pkg::*;

    localparam int CREDIT_WIDTH = $clog2(NUM_CREDITS + 1);

    logic [CREDIT_WIDTH-1:0] credits;
    logic [ID_WIDTH-1:0]     last_id;
    logic [ID_WIDTH-1:0]     grant_id;
    logic                    issue;

    // ----------------------------------------
    // Round-robin search after the last winner
    // ----------------------------------------
    always_comb begin
        int  idx;
        logic found;
        idx      = 0;
        found    = 1'b0;
        grant_id = last_id;
        for (int i = 1; i <= NUM_ENGINES; i++) begin
            idx = (int'(last_id) + i) % NUM_ENGINES;
            if (!found && not_empty[idx]) begin
                found    = 1'b1;
                grant_id = ID_WIDTH'(idx);
            end
        end
    end

    assign issue = (credits != '0) && (|not_empty);

    always_comb begin
        pop = '0;
        if (issue) begin
            pop[grant_id] = 1'b1;
        end
    end

    // ----------------------------------------
    // Credits and registered request
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (engine_areset) begin
            credits   <= CREDIT_WIDTH'(NUM_CREDITS);
            last_id   <= ID_WIDTH'(NUM_ENGINES - 1);
            req_valid <= 1'b0;
        end else begin
            case ({credit_return, issue})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            if (issue) begin
                last_id <= grant_id;
            end
            req_valid <= issue;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (issue) begin
            req_engine_id      <= grant_id;
            req_base_address   <= array_pointer[grant_id];
            req_address_offset <= head_offset[grant_id];
        end
    end

endmodule : request_arbiter

// File: design/read_engine_cluster_top.sv
// Read engine cluster
// Peer serial read engines sharing one credit-controlled memory
// request port through a round-robin arbiter

module read_engine_cluster_top #(
    parameter int NUM_ENGINES = read_engine_pkg::DEFAULT_NUM_ENGINES,
    parameter int FIFO_DEPTH  = read_engine_pkg::DEFAULT_FIFO_DEPTH,
    parameter int NUM_CREDITS = read_engine_pkg::DEFAULT_NUM_CREDITS,
    localparam int ID_WIDTH   = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1
) (
    input  logic                   ap_clk,
    input  logic                   engine_areset,
    input  logic [NUM_ENGINES-1:0] cfg_valid,
    input  logic [NUM_ENGINES-1:0] start,
    input  read_engine_pkg::addr_t array_pointer [NUM_ENGINES],
    input  read_engine_pkg::addr_t start_read [NUM_ENGINES],
    input  read_engine_pkg::addr_t end_read [NUM_ENGINES],
    input  read_engine_pkg::addr_t stride [NUM_ENGINES],
    output logic [NUM_ENGINES-1:0] ready,
    output logic [NUM_ENGINES-1:0] done,
    output logic                   req_valid,
    output logic [ID_WIDTH-1:0]    req_engine_id,
    output read_engine_pkg::addr_t req_base_address,
    output read_engine_pkg::addr_t req_address_offset,
    input  logic                   credit_return
);
    import read_engine_pkg::*;

    logic [NUM_ENGINES-1:0] engine_not_empty;
    logic [NUM_ENGINES-1:0] engine_pop;
    addr_t                  engine_head [NUM_ENGINES];

    // ----------------------------------------
    // Peer engines
    // ----------------------------------------
    for (genvar i = 0; i < NUM_ENGINES; i++) begin : g_engine
        serial_read_engine #(
            .ENGINE_ID (i),
            .FIFO_DEPTH(FIFO_DEPTH)
        ) u_engine (
            .ap_clk       (ap_clk),
            .engine_areset(engine_areset),
            .cfg_valid    (cfg_valid[i]),
            .start        (start[i]),
            .start_read   (start_read[i]),
            .end_read     (end_read[i]),
            .stride       (stride[i]),
            .ready        (ready[i]),
            .done         (done[i]),
            .pop          (engine_pop[i]),
            .not_empty    (engine_not_empty[i]),
            .head_offset  (engine_head[i])
        );
    end

    // Base address is picked per grant inside the arbiter
    request_arbiter #(
        .NUM_ENGINES(NUM_ENGINES),
        .NUM_CREDITS(NUM_CREDITS)
    ) u_arbiter (
        .ap_clk            (ap_clk),
        .engine_areset     (engine_areset),
        .not_empty         (engine_not_empty),
        .head_offset       (engine_head),
        .array_pointer     (array_pointer),
        .pop               (engine_pop),
        .credit_return     (credit_return),
        .req_valid         (req_valid),
        .req_engine_id     (req_engine_id),
        .req_base_address  (req_base_address),
        .req_address_offset(req_address_offset)
    );

endmodule : read_engine_cluster_top

// File: sim/request_arbiter_checker.sv
// Request arbiter checker
// Credit and grant assertions bound into every request_arbiter

module request_arbiter_checker #(
    parameter int NUM_ENGINES  = read_engine_pkg::DEFAULT_NUM_ENGINES,
    parameter int NUM_CREDITS  = read_engine_pkg::DEFAULT_NUM_CREDITS,
    localparam int CREDIT_WIDTH = $clog2(NUM_CREDITS + 1)
) (
    input logic                    ap_clk,
    input logic                    engine_areset,
    input logic [NUM_ENGINES-1:0]  not_empty,
    input logic [NUM_ENGINES-1:0]  pop,
    input logic                    credit_return,
    input logic [CREDIT_WIDTH-1:0] credits
);
    int failure_count = 0;
    int in_flight;

    // Issues not yet paid back by a returned credit
    always_ff @(posedge ap_clk) begin
        if (engine_areset) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(|pop) - int'(credit_return);
        end
    end

    // No FIFO pop, and so no issue, once every credit is in use
    no_issue_without_credit : assert property (@(posedge ap_clk) disable iff (engine_areset)
        (|pop) |-> (in_flight < NUM_CREDITS))
    else begin
        failure_count++;
        $error("Request issued with zero credits");
    end

    credits_within_limit : assert property (@(posedge ap_clk) disable iff (engine_areset)
        credits <= CREDIT_WIDTH'(NUM_CREDITS))
    else begin
        failure_count++;
        $error("Credit count above the memory side limit");
    end

    // One engine at a time, and never one with an empty FIFO
    single_pop : assert property (@(posedge ap_clk) disable iff (engine_areset)
        $onehot0(pop) && ((pop & ~not_empty) == '0))
    else begin
        failure_count++;
        $error("More than one engine popped, or an empty FIFO was popped");
    end

endmodule : request_arbiter_checker

bind request_arbiter request_arbiter_checker #(
    .NUM_ENGINES(NUM_ENGINES),
    .NUM_CREDITS(NUM_CREDITS)
) u_arbiter_checker (
    .ap_clk       (ap_clk),
    .engine_areset(engine_areset),
    .not_empty    (not_empty),
    .pop          (pop),
    .credit_return(credit_return),
    .credits      (credits)
);

// File: sim/read_engine_tb.sv
// Read engine cluster testbench
// Runs single, paired, credit-starved, paused and empty-range reads
// and checks every request against a reference offset sequence

module read_engine_tb;
    import read_engine_pkg::*;

    localparam int NUM_ENGINES = DEFAULT_NUM_ENGINES;
    localparam int FIFO_DEPTH  = DEFAULT_FIFO_DEPTH;
    localparam int NUM_CREDITS = DEFAULT_NUM_CREDITS;
    localparam int ID_WIDTH    = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1;
    localparam int CLK_PERIOD  = 100;
    localparam int RUN_LIMIT   = 2000;

    typedef addr_t offset_q_t[$];

    logic                   ap_clk;
    logic                   engine_areset;
    logic [NUM_ENGINES-1:0] cfg_valid;
    logic [NUM_ENGINES-1:0] start;
    addr_t                  array_pointer [NUM_ENGINES];
    addr_t                  start_read [NUM_ENGINES];
    addr_t                  end_read [NUM_ENGINES];
    addr_t                  stride [NUM_ENGINES];
    logic [NUM_ENGINES-1:0] ready;
    logic [NUM_ENGINES-1:0] done;
    logic                   req_valid;
    logic [ID_WIDTH-1:0]    req_engine_id;
    addr_t                  req_base_address;
    addr_t                  req_address_offset;
    logic                   credit_return;

    integer    seed = 97017;
    string     test_name = "reset";
    offset_q_t exp_q [NUM_ENGINES];
    addr_t     exp_base [NUM_ENGINES];
    int        exp_len [NUM_ENGINES];
    int        got_count [NUM_ENGINES];
    addr_t     rnd_start [NUM_ENGINES];
    addr_t     rnd_end [NUM_ENGINES];
    addr_t     rnd_stride [NUM_ENGINES];
    int        pending [$];
    int        outstanding = 0;
    int        cycle = 0;
    int        credit_delay = 0;
    logic      withhold = 1'b0;
    int        watchdog_cycles = 0;
    int        errors = 0;

    read_engine_cluster_top #(
        .NUM_ENGINES(NUM_ENGINES),
        .FIFO_DEPTH (FIFO_DEPTH),
        .NUM_CREDITS(NUM_CREDITS)
    ) dut (
        .ap_clk            (ap_clk),
        .engine_areset     (engine_areset),
        .cfg_valid         (cfg_valid),
        .start             (start),
        .array_pointer     (array_pointer),
        .start_read        (start_read),
        .end_read          (end_read),
        .stride            (stride),
        .ready             (ready),
        .done              (done),
        .req_valid         (req_valid),
        .req_engine_id     (req_engine_id),
        .req_base_address  (req_base_address),
        .req_address_offset(req_address_offset),
        .credit_return     (credit_return)
    );

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    // ----------------------------------------
    // Reference model and checks
    // ----------------------------------------
    function automatic offset_q_t ref_sequence(addr_t from_offset, addr_t to_offset,
                                               addr_t step);
        offset_q_t seq;
        addr_t     off;
        off = from_offset;
        while (off < to_offset) begin
            seq.push_back(off);
            off = off + step;
        end
        return seq;
    endfunction

    function automatic int offset_count(addr_t from_offset, addr_t to_offset, addr_t step);
        offset_q_t seq;
        seq = ref_sequence(from_offset, to_offset, step);
        return seq.size();
    endfunction

    task automatic stop_run(input string what);
        errors++;
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_addr(input string field, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("** Error: %s %s expected %h actual %h",
                               test_name, field, expected, actual));
        end
    endtask

    task automatic check_count(input string field, input int expected, input int actual);
        if (actual != expected) begin
            stop_run($sformatf("** Error: %s %s expected %0d actual %0d",
                               test_name, field, expected, actual));
        end
    endtask

    task automatic check_flag(input string field, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_run($sformatf("** Error: %s %s expected %b actual %b",
                               test_name, field, expected, actual));
        end
    endtask

    // Every request on the shared port is matched to its engine's stream
    always @(negedge ap_clk) begin : compare_requests
        int    eid;
        addr_t expected;
        if (!engine_areset && req_valid) begin
            eid = int'(req_engine_id);
            if (eid >= NUM_ENGINES || exp_q[eid].size() == 0) begin
                stop_run($sformatf("%s: engine %0d issued a request beyond its range",
                                   test_name, eid));
            end else begin
                expected = exp_q[eid].pop_front();
                check_addr($sformatf("engine %0d base", eid), exp_base[eid], req_base_address);
                check_addr($sformatf("engine %0d offset", eid), expected, req_address_offset);
                got_count[eid]++;
            end
        end
    end

    always @(negedge ap_clk) begin : watch_checker
        if (dut.u_arbiter.u_arbiter_checker.failure_count != 0) begin
            stop_run($sformatf("%s: an arbiter assertion failed", test_name));
        end
    end

    // Memory side model returning one credit per request after credit_delay cycles
    always @(negedge ap_clk) begin : return_credits
        if (engine_areset) begin
            outstanding = 0;
            pending.delete();
            credit_return = 1'b0;
        end else begin
            if (req_valid) begin
                outstanding++;
                pending.push_back(cycle + credit_delay);
            end
            if (credit_return) begin
                outstanding--;
            end
            if (outstanding > NUM_CREDITS) begin
                stop_run($sformatf("%s: %0d requests outstanding with only %0d credits",
                                   test_name, outstanding, NUM_CREDITS));
            end
            credit_return = 1'b0;
            if (!withhold && pending.size() > 0 && pending[0] <= cycle) begin
                void'(pending.pop_front());
                credit_return = 1'b1;
            end
        end
        cycle++;
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge ap_clk);
        stop_run($sformatf("Watchdog expired after %0d cycles", watchdog_cycles));
    end

    // ----------------------------------------
    // Run control
    // ----------------------------------------
    task automatic set_config(input int eng, input addr_t base, input addr_t from_offset,
                              input addr_t to_offset, input addr_t step);
        array_pointer[eng] = base;
        start_read[eng]    = from_offset;
        end_read[eng]      = to_offset;
        stride[eng]        = step;
        exp_base[eng]      = base;
        exp_q[eng]         = ref_sequence(from_offset, to_offset, step);
        exp_len[eng]       = exp_q[eng].size();
        got_count[eng]     = 0;
    endtask

    // Changed on a rising edge so the credit model never sees it mid-update
    task automatic set_credit_mode(input logic hold, input int delay);
        @(posedge ap_clk);
        withhold     = hold;
        credit_delay = delay;
        @(negedge ap_clk);
    endtask

    task automatic start_run(input logic [NUM_ENGINES-1:0] mask);
        cfg_valid = mask;
        start     = mask;
        @(negedge ap_clk);
        check_flag("ready after start", 1'b0, |(ready & mask));
    endtask

    task automatic wait_run(input logic [NUM_ENGINES-1:0] mask);
        int                     waited;
        logic [NUM_ENGINES-1:0] seen;
        waited = 0;
        seen   = '0;
        while ((done & mask) != mask) begin
            check_flag("ready while running", 1'b0, |(ready & mask));
            check_flag("done held once raised", 1'b1, (done & seen) == seen);
            seen = seen | (done & mask);
            @(negedge ap_clk);
            waited++;
            if (waited > RUN_LIMIT) begin
                stop_run($sformatf("%s: engines never raised done", test_name));
            end
        end
    endtask

    task automatic wait_pause();
        int waited;
        waited = 0;
        while (dut.g_engine[0].u_engine.state != PAUSE) begin
            @(negedge ap_clk);
            waited++;
            if (waited > 200) begin
                stop_run($sformatf("%s: engine 0 never paused on a full FIFO", test_name));
            end
        end
    endtask

    task automatic end_run(input logic [NUM_ENGINES-1:0] mask);
        @(posedge ap_clk);
        for (int e = 0; e < NUM_ENGINES; e++) begin
            if (mask[e]) begin
                check_count($sformatf("engine %0d request count", e), exp_len[e], got_count[e]);
                check_count($sformatf("engine %0d requests missing", e), 0, exp_q[e].size());
            end
        end
        repeat (3) begin
            @(negedge ap_clk);
            check_flag("done until start falls", 1'b1, (done & mask) == mask);
            check_flag("ready until start falls", 1'b0, |(ready & mask));
        end
        start     = '0;
        cfg_valid = '0;
        repeat (2) @(negedge ap_clk);
        check_flag("ready after start falls", 1'b1, (ready & mask) == mask);
        check_flag("done after start falls", 1'b0, |(done & mask));
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : main
        int total;
        ap_clk        = 1'b0;
        engine_areset = 1'b1;
        cfg_valid     = '0;
        start         = '0;
        credit_return = 1'b0;
        for (int e = 0; e < NUM_ENGINES; e++) begin
            array_pointer[e] = '0;
            start_read[e]    = '0;
            end_read[e]      = '0;
            stride[e]        = '0;
            rnd_start[e]     = $unsigned($random(seed)) % 64;
            rnd_end[e]       = rnd_start[e] + $unsigned($random(seed)) % 48;
            rnd_stride[e]    = 1 + $unsigned($random(seed)) % 6;
        end

        // Watchdog budget from every run's request count
        total = offset_count(5, 40, 3) + offset_count(100, 130, 2) + offset_count(0, 48, 1);
        for (int e = 0; e < NUM_ENGINES; e++) begin
            total += offset_count(rnd_start[e], rnd_end[e], rnd_stride[e]);
        end
        watchdog_cycles = 20 * total + 200;

        repeat (2) @(negedge ap_clk);
        check_flag("req_valid in reset", 1'b0, req_valid);
        check_flag("done in reset", 1'b0, |done);
        engine_areset = 1'b0;
        repeat (2) @(negedge ap_clk);
        check_flag("ready after reset", 1'b1, &ready);

        test_name = "single engine";
        set_credit_mode(1'b0, 3);
        set_config(0, 32'h1000_0000, 5, 40, 3);
        start_run(2'b01);
        wait_run(2'b01);
        end_run(2'b01);

        test_name = "two engines random";
        set_credit_mode(1'b0, 0);
        for (int e = 0; e < NUM_ENGINES; e++) begin
            set_config(e, 32'h2000_0000 + e * 32'h0100_0000, rnd_start[e], rnd_end[e],
                       rnd_stride[e]);
        end
        start_run(2'b11);
        wait_run(2'b11);
        end_run(2'b11);

        test_name = "credits withheld";
        set_credit_mode(1'b1, 1);
        set_config(1, 32'h4000_0000, 100, 130, 2);
        start_run(2'b10);
        repeat (30) @(negedge ap_clk);
        @(posedge ap_clk);
        check_count("outstanding while withheld", NUM_CREDITS, outstanding);
        set_credit_mode(1'b0, 1);
        wait_run(2'b10);
        end_run(2'b10);

        test_name = "fifo pause";
        set_credit_mode(1'b1, 0);
        set_config(0, 32'h5000_0000, 0, 48, 1);
        start_run(2'b01);
        wait_pause();
        set_credit_mode(1'b0, 0);
        wait_run(2'b01);
        end_run(2'b01);

        test_name = "empty range";
        set_config(1, 32'h6000_0000, 30, 10, 4);
        start_run(2'b10);
        wait_run(2'b10);
        end_run(2'b10);

        errors += dut.u_arbiter.u_arbiter_checker.failure_count;
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : read_engine_tb

// File: filelist.f
design/read_engine_pkg.sv
design/request_fifo.sv
design/serial_read_engine.sv
design/request_arbiter.sv
design/read_engine_cluster_top.sv
sim/request_arbiter_checker.sv
sim/read_engine_tb.sv

// File: Bender.yml
package:
  name: read_engine_cluster

sources:
  - files:
      - design/read_engine_pkg.sv
      - design/request_fifo.sv
      - design/serial_read_engine.sv
      - design/request_arbiter.sv
      - design/read_engine_cluster_top.sv

  - target: simulation
    files:
      - sim/request_arbiter_checker.sv
      - sim/read_engine_tb.sv
